/* hw/scaler_pkg.sv */
package scaler_pkg;

	localparam int FRAC_BITS = 8;                      // fraction bits of a scale factor
	localparam int SRC_ROWS  = 8;
	localparam int SRC_COLS  = 8;
	localparam int TGT_ROWS  = 12;
	localparam int TGT_COLS  = 12;
	localparam int BANK_COLS = SRC_COLS / 2;           // words per bank row
	localparam int TGT_PIXELS = TGT_ROWS * TGT_COLS;
	localparam int FRAC_ONE  = 1 << (FRAC_BITS + 1);   // one source pixel in half steps

	typedef logic [7:0]  pixel_t;
	typedef logic [15:0] scale_t;                      // src size / tgt size, FRAC_BITS frac
	typedef logic [15:0] index_t;
	typedef logic [15:0] coord_t;
	typedef logic [FRAC_BITS:0] frac_t;

	// one extra bit so that a full weight of FRAC_ONE squared still fits
	typedef logic [2*FRAC_BITS+2:0] weight_t;

	typedef logic [15:0] addr_t;

	typedef enum logic [1:0]
	{
		ST_IDLE  = 2'b00,
		ST_ARMED = 2'b01,
		ST_RUN   = 2'b11
	} scan_state_e;

endpackage

/* hw/coord_if.sv */
`timescale 1ns/1ps

interface coord_if import scaler_pkg::*; ();

	logic   valid;
	coord_t row_int;   // top-left source row
	coord_t col_int;   // top-left source column
	frac_t  row_frac;
	frac_t  col_frac;

	modport src
	(
		output valid, row_int, col_int, row_frac, col_frac
	);

	modport dst
	(
		input valid, row_int, col_int, row_frac, col_frac
	);

endinterface

/* hw/scan_ctrl.sv */
`timescale 1ns/1ps

module scan_ctrl import scaler_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  logic   src_ready,
	input  logic   pix_valid,
	output logic   idx_valid,
	output index_t row_idx,
	output index_t col_idx,
	output logic   done
);

	scan_state_e state;
	logic        start_q;
	logic        start_rise;
	logic        issue_done;    // all target indices sent
	index_t      row_cnt;
	index_t      col_cnt;
	index_t      pix_cnt;
	logic        last_idx;
	logic        last_pix;

	assign start_rise = start & ~start_q;
	assign last_idx   = (row_cnt == TGT_ROWS - 1) && (col_cnt == TGT_COLS - 1);
	assign last_pix   = pix_valid && (pix_cnt == TGT_PIXELS - 1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= ST_IDLE;
			start_q    <= 1'b0;
			issue_done <= 1'b0;
			row_cnt    <= '0;
			col_cnt    <= '0;
			pix_cnt    <= '0;
			idx_valid  <= 1'b0;
			done       <= 1'b0;
		end
		else
		begin
			start_q   <= start;
			idx_valid <= 1'b0;
			done      <= 1'b0;
			case (state)
				ST_IDLE:
					if (start_rise)
						state <= ST_ARMED;
				ST_ARMED:
					if (src_ready)
						state <= ST_RUN;
				ST_RUN:
				begin
					if (!issue_done)
					begin
						idx_valid <= 1'b1;
						if (col_cnt == TGT_COLS - 1)   // wrap into next row
						begin
							col_cnt <= '0;
							row_cnt <= row_cnt + 1'b1;
						end
						else
							col_cnt <= col_cnt + 1'b1;
						if (last_idx)
							issue_done <= 1'b1;
					end
					if (pix_valid)
						pix_cnt <= pix_cnt + 1'b1;
					if (last_pix)   // frame drained, back to idle
					begin
						done       <= 1'b1;
						state      <= ST_IDLE;
						issue_done <= 1'b0;
						row_cnt    <= '0;
						col_cnt    <= '0;
						pix_cnt    <= '0;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_RUN && !issue_done)
		begin
			row_idx <= row_cnt;
			col_idx <= col_cnt;
		end
	end

endmodule

/* hw/coord_map.sv */
`timescale 1ns/1ps

module coord_map import scaler_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   idx_valid,
	input  index_t row_idx,
	input  index_t col_idx,
	input  scale_t scale_x,   // column step
	input  scale_t scale_y,   // row step
	coord_if.src   coord
);

	logic valid_a;
	int   pos_row;   // centre position in half steps, may be negative
	int   pos_col;

	function automatic coord_t to_int(int pos, int last);
		int i;
		i = (pos < 0) ? 0 : (pos >>> (FRAC_BITS + 1));
		return coord_t'((i > last) ? last : i);
	endfunction

	function automatic frac_t to_frac(int pos);
		return (pos < 0) ? '0 : frac_t'(pos);
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_a     <= 1'b0;
			coord.valid <= 1'b0;
		end
		else
		begin
			valid_a     <= idx_valid;
			coord.valid <= valid_a;
		end
	end

	always_ff @(posedge clk)
	begin
		// (2i+1)*scale - half a pixel
		pos_row <= int'(2 * row_idx + 1) * int'(scale_y) - (1 << FRAC_BITS);
		pos_col <= int'(2 * col_idx + 1) * int'(scale_x) - (1 << FRAC_BITS);

		coord.row_int  <= to_int(pos_row, SRC_ROWS - 1);
		coord.col_int  <= to_int(pos_col, SRC_COLS - 1);
		coord.row_frac <= to_frac(pos_row);
		coord.col_frac <= to_frac(pos_col);
	end

endmodule

/* hw/bank_fetch.sv */
`timescale 1ns/1ps

module bank_fetch import scaler_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	coord_if.dst   coord,
	input  pixel_t bank_q0,
	input  pixel_t bank_q1,
	input  pixel_t bank_q2,
	input  pixel_t bank_q3,
	output logic   bank_rd,
	output addr_t  bank_addr0,
	output addr_t  bank_addr1,
	output addr_t  bank_addr2,
	output addr_t  bank_addr3,
	output logic   corner_valid,
	output pixel_t tl,
	output pixel_t tr,
	output pixel_t bl,
	output pixel_t br
);

	logic   row_edge, col_edge;
	coord_t row_nb, col_nb;       // lower / right neighbours
	logic   row_par_a, col_par_a, row_edge_a, col_edge_a;
	logic   row_par_b, col_par_b, row_edge_b, col_edge_b;
	logic   row_nb_par, col_nb_par;
	pixel_t bank_q [4];

	function automatic addr_t word_addr(coord_t row, coord_t col);
		return addr_t'((row >> 1) * BANK_COLS + (col >> 1));
	endfunction

	// of the two candidates, the one with the wanted parity
	function automatic coord_t pick(coord_t a, coord_t b, logic par);
		return (a[0] == par) ? a : b;
	endfunction

	assign row_edge = (coord.row_int == SRC_ROWS - 1);
	assign col_edge = (coord.col_int == SRC_COLS - 1);
	assign row_nb   = row_edge ? coord.row_int : coord.row_int + 1'b1;
	assign col_nb   = col_edge ? coord.col_int : coord.col_int + 1'b1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bank_rd      <= 1'b0;
			corner_valid <= 1'b0;
		end
		else
		begin
			bank_rd      <= coord.valid;
			corner_valid <= bank_rd;   // data back one cycle after the read
		end
	end

	always_ff @(posedge clk)
	begin
		bank_addr0 <= word_addr(pick(coord.row_int, row_nb, 1'b0), pick(coord.col_int, col_nb, 1'b0));
		bank_addr1 <= word_addr(pick(coord.row_int, row_nb, 1'b0), pick(coord.col_int, col_nb, 1'b1));
		bank_addr2 <= word_addr(pick(coord.row_int, row_nb, 1'b1), pick(coord.col_int, col_nb, 1'b0));
		bank_addr3 <= word_addr(pick(coord.row_int, row_nb, 1'b1), pick(coord.col_int, col_nb, 1'b1));
		row_par_a  <= coord.row_int[0];
		col_par_a  <= coord.col_int[0];
		row_edge_a <= row_edge;
		col_edge_a <= col_edge;
		row_par_b  <= row_par_a;
		col_par_b  <= col_par_a;
		row_edge_b <= row_edge_a;
		col_edge_b <= col_edge_a;
	end

	assign bank_q = '{bank_q0, bank_q1, bank_q2, bank_q3};

	// neighbour flips parity unless clamped at the edge
	assign row_nb_par = row_par_b ^ ~row_edge_b;
	assign col_nb_par = col_par_b ^ ~col_edge_b;

	assign tl = bank_q[{row_par_b, col_par_b}];
	assign tr = bank_q[{row_par_b, col_nb_par}];
	assign bl = bank_q[{row_nb_par, col_par_b}];
	assign br = bank_q[{row_nb_par, col_nb_par}];

endmodule

/* hw/weight_calc.sv */
`timescale 1ns/1ps

module weight_calc import scaler_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	coord_if.dst    coord,
	output weight_t w_tl,
	output weight_t w_tr,
	output weight_t w_bl,
	output weight_t w_br
);

	weight_t w_tl_a, w_tr_a, w_bl_a, w_br_a;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			w_tl_a <= '0;
			w_tr_a <= '0;
			w_bl_a <= '0;
			w_br_a <= '0;
			w_tl   <= '0;
			w_tr   <= '0;
			w_bl   <= '0;
			w_br   <= '0;
		end
		else
		begin
			if (coord.valid)
			begin
				w_tl_a <= weight_t'((FRAC_ONE - coord.row_frac) * (FRAC_ONE - coord.col_frac));
				w_tr_a <= weight_t'((FRAC_ONE - coord.row_frac) * coord.col_frac);
				w_bl_a <= weight_t'(coord.row_frac * (FRAC_ONE - coord.col_frac));
				w_br_a <= weight_t'(coord.row_frac * coord.col_frac);
			end
			w_tl <= w_tl_a;   // wait for the bank read
			w_tr <= w_tr_a;
			w_bl <= w_bl_a;
			w_br <= w_br_a;
		end
	end

endmodule

/* hw/blend.sv */
`timescale 1ns/1ps

module blend import scaler_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    corner_valid,
	input  pixel_t  tl,
	input  pixel_t  tr,
	input  pixel_t  bl,
	input  pixel_t  br,
	input  weight_t w_tl,
	input  weight_t w_tr,
	input  weight_t w_bl,
	input  weight_t w_br,
	output logic    pix_valid,
	output pixel_t  pix
);

	logic                        sum_valid;
	logic [$bits(weight_t)+8:0]  sum_a;   // diagonal pair
	logic [$bits(weight_t)+8:0]  sum_b;   // anti-diagonal pair

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sum_valid <= 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			sum_valid <= corner_valid;
			pix_valid <= sum_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (corner_valid)
		begin
			sum_a <= w_tl * tl + w_br * br;
			sum_b <= w_tr * tr + w_bl * bl;
		end
		if (sum_valid)
			pix <= pixel_t'((sum_a + sum_b) >> (2 * (FRAC_BITS + 1)));   // drop weight scale
	end

endmodule

/* hw/scaler_top.sv */
`timescale 1ns/1ps

module scaler_top import scaler_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  logic   src_ready,
	input  scale_t scale_x,
	input  scale_t scale_y,
	input  pixel_t bank_q0,
	input  pixel_t bank_q1,
	input  pixel_t bank_q2,
	input  pixel_t bank_q3,
	output logic   bank_rd,
	output addr_t  bank_addr0,
	output addr_t  bank_addr1,
	output addr_t  bank_addr2,
	output addr_t  bank_addr3,
	output logic   pix_valid,
	output pixel_t pix,
	output logic   done
);

	logic    idx_valid;
	index_t  row_idx, col_idx;
	logic    corner_valid;
	pixel_t  tl, tr, bl, br;
	weight_t w_tl, w_tr, w_bl, w_br;

	coord_if coord_bus ();

	scan_ctrl u_scan (.clk, .rst, .start, .src_ready, .pix_valid,
		.idx_valid, .row_idx, .col_idx, .done);

	coord_map u_map (.clk, .rst, .idx_valid, .row_idx, .col_idx,
		.scale_x, .scale_y, .coord(coord_bus.src));

	bank_fetch u_fetch (.clk, .rst, .coord(coord_bus.dst),
		.bank_q0, .bank_q1, .bank_q2, .bank_q3,
		.bank_rd, .bank_addr0, .bank_addr1, .bank_addr2, .bank_addr3,
		.corner_valid, .tl, .tr, .bl, .br);

	weight_calc u_weight (.clk, .rst, .coord(coord_bus.dst),
		.w_tl, .w_tr, .w_bl, .w_br);

	blend u_blend (.clk, .rst, .corner_valid, .tl, .tr, .bl, .br,
		.w_tl, .w_tr, .w_bl, .w_br, .pix_valid, .pix);

endmodule

/* tests/tb_scaler.sv */
`timescale 1ns/1ps

module tb_scaler import scaler_pkg::*; ();

	localparam int N_FRAMES   = 2;
	localparam int MAX_CYCLES = 2 * (N_FRAMES * (TGT_PIXELS + 20));
	localparam int BANK_WORDS = SRC_ROWS * SRC_COLS / 4;

	logic   clk, rst, start, src_ready;
	scale_t scale_x, scale_y;
	pixel_t bank_q0, bank_q1, bank_q2, bank_q3;
	logic   bank_rd;
	addr_t  bank_addr0, bank_addr1, bank_addr2, bank_addr3;
	logic   pix_valid;
	pixel_t pix;
	logic   done;

	pixel_t bank_mem [4][BANK_WORDS];
	pixel_t src_img [N_FRAMES][SRC_ROWS][SRC_COLS];
	pixel_t expected [N_FRAMES][TGT_PIXELS];
	scale_t frame_sx [N_FRAMES];
	scale_t frame_sy [N_FRAMES];
	int     fd;
	logic   expect_idle = 1'b0;   // outputs must stay quiet
	int     cycles = 0;
	int     pix_count = 0;
	int     out_frame = 0;
	int     last_valid = 0;

	scaler_top dut0 (.clk, .rst, .start, .src_ready, .scale_x, .scale_y,
		.bank_q0, .bank_q1, .bank_q2, .bank_q3,
		.bank_rd, .bank_addr0, .bank_addr1, .bank_addr2, .bank_addr3,
		.pix_valid, .pix, .done);

	always #20 clk = ~clk;

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_pixel(pixel_t got, pixel_t exp, string what);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t: %s: got %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_count(index_t got, index_t exp, string what);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t: %s: got %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t: %s: got %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic read_number(output int value);
		if ($fscanf(fd, "%d", value) != 1)
			report_failure("the test data file ended early or holds a bad number");
	endtask

	// bank = 2*(r mod 2) + (c mod 2), word = (r/2)*BANK_COLS + c/2
	task automatic load_banks(int f);
		int r, c;
		for (r = 0; r < SRC_ROWS; r++)
			for (c = 0; c < SRC_COLS; c++)
				bank_mem[2 * (r % 2) + (c % 2)][(r / 2) * BANK_COLS + c / 2] =
					src_img[f][r][c];
	endtask

	task automatic wait_for_done();
		do
			@(posedge clk);
		while (done !== 1'b1);
	endtask

	// one-cycle synchronous bank read
	always @(posedge clk)
	begin
		if (bank_rd)
		begin
			bank_q0 <= bank_mem[0][bank_addr0];
			bank_q1 <= bank_mem[1][bank_addr1];
			bank_q2 <= bank_mem[2][bank_addr2];
			bank_q3 <= bank_mem[3][bank_addr3];
		end
	end

	// output monitor, samples last cycle's values
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES)
			report_failure($sformatf("timeout: both frames not finished within %0d cycles",
				MAX_CYCLES));
		if (expect_idle)
		begin
			check_flag(pix_valid, 1'b0, "pix_valid while idle");
			check_flag(done, 1'b0, "done while idle");
			check_flag(bank_rd, 1'b0, "bank_rd while idle");
		end
		if (pix_valid === 1'b1)
		begin
			if (out_frame >= N_FRAMES || pix_count >= TGT_PIXELS)
				report_failure("a pixel came out with no expected pixel left in the frame");
			else
			begin
				check_pixel(pix, expected[out_frame][pix_count],
					$sformatf("frame %0d pixel %0d", out_frame, pix_count));
				pix_count  = pix_count + 1;
				last_valid = cycles;
			end
		end
		if (done === 1'b1)
		begin
			check_count(index_t'(pix_count), index_t'(TGT_PIXELS), "pixels in frame");
			check_count(index_t'(cycles - last_valid), index_t'(1),
				"cycles from last pixel to done");
			out_frame = out_frame + 1;
			pix_count = 0;
		end
	end

	initial
	begin
		int          f, i, r, c, v, sx, sy, delay;
		logic [8*160-1:0] text_line;

		void'($urandom(32'h3e8b));
		clk       = 1'b0;
		rst       = 1'b1;
		start     = 1'b0;
		src_ready = 1'b0;
		scale_x   = '0;
		scale_y   = '0;
		bank_q0   = '0;
		bank_q1   = '0;
		bank_q2   = '0;
		bank_q3   = '0;

		fd = $fopen("tests/scaler_testdata.txt", "r");
		if (fd == 0)
			report_failure("could not open tests/scaler_testdata.txt");
		void'($fgets(text_line, fd));   // two column header lines
		void'($fgets(text_line, fd));
		for (f = 0; f < N_FRAMES; f++)
		begin
			read_number(sx);
			read_number(sy);
			frame_sx[f] = scale_t'(sx);
			frame_sy[f] = scale_t'(sy);
			for (r = 0; r < SRC_ROWS; r++)
				for (c = 0; c < SRC_COLS; c++)
				begin
					read_number(v);
					src_img[f][r][c] = pixel_t'(v);
				end
			for (i = 0; i < TGT_PIXELS; i++)
			begin
				read_number(v);
				expected[f][i] = pixel_t'(v);
			end
		end
		$fclose(fd);

		@(posedge clk);
		expect_idle <= 1'b1;
		repeat (7) @(posedge clk);
		rst <= 1'b0;

		for (f = 0; f < N_FRAMES; f++)
		begin
			load_banks(f);
			@(posedge clk);
			scale_x     <= frame_sx[f];
			scale_y     <= frame_sy[f];
			start       <= 1'b1;
			expect_idle <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			delay = 10 + ($urandom % 6);   // memory not ready yet
			repeat (delay) @(posedge clk);
			src_ready   <= 1'b1;
			expect_idle <= 1'b0;
			repeat (TGT_PIXELS / 2) @(posedge clk);
			start <= 1'b1;   // ignored mid-frame
			@(posedge clk);
			start <= 1'b0;
			wait_for_done();
			src_ready   <= 1'b0;
			expect_idle <= 1'b1;
		end

		repeat (4) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

/* all.f */
hw/scaler_pkg.sv
hw/coord_if.sv
hw/scan_ctrl.sv
hw/coord_map.sv
hw/bank_fetch.sv
hw/weight_calc.sv
hw/blend.sv
hw/scaler_top.sv
tests/tb_scaler.sv

/* tests/scaler_testdata.txt */
# per frame: scale_x scale_y, then 8 source rows of 8 pixels (decimal)
# then 144 expected output pixels in raster order, 12 per line
170 170
10 14 18 22 26 30 34 38
26 30 34 38 42 46 50 54
42 46 50 54 58 62 66 70
58 62 66 70 74 78 82 86
74 78 82 86 90 94 98 102
90 94 98 102 106 110 114 118
106 110 114 118 122 126 130 134
122 126 130 134 138 142 146 150
10 11 14 17 19 22 25 27 30 33 35 38
17 19 22 25 27 30 33 35 38 41 43 45
28 30 33 35 38 41 43 46 49 51 54 56
39 41 43 46 49 51 54 57 59 62 65 67
49 51 54 57 59 62 65 67 70 73 75 77
60 62 65 67 70 73 75 78 81 83 86 88
71 73 75 78 81 83 86 88 91 94 96 99
81 83 86 88 91 94 96 99 102 104 107 109
92 94 96 99 102 104 107 110 112 115 118 120
102 104 107 110 112 115 118 120 123 126 128 130
113 115 118 120 123 126 128 131 134 136 139 141
122 123 126 129 131 134 137 139 142 145 147 150
160 192
20 44 68 92 116 140 164 188
28 52 76 100 124 148 172 196
36 60 84 108 132 156 180 204
44 68 92 116 140 164 188 212
52 76 100 124 148 172 196 220
60 84 108 132 156 180 204 228
68 92 116 140 164 188 212 236
76 100 124 148 172 196 220 244
20 30 45 60 75 90 105 120 135 150 165 180
25 35 50 65 80 95 110 125 140 155 170 185
31 41 56 71 86 101 116 131 146 161 176 191
37 47 62 77 92 107 122 137 152 167 182 197
43 53 68 83 98 113 128 143 158 173 188 203
49 59 74 89 104 119 134 149 164 179 194 209
55 65 80 95 110 125 140 155 170 185 200 215
61 71 86 101 116 131 146 161 176 191 206 221
67 77 92 107 122 137 152 167 182 197 212 227
73 83 98 113 128 143 158 173 188 203 218 233
76 86 101 116 131 146 161 176 191 206 221 236
76 86 101 116 131 146 161 176 191 206 221 236
